//--- source/hsid_pkg.sv
package hsid_pkg;

  localparam int WORD_WIDTH     = 32;  // One element word
  localparam int DATA_WIDTH     = 16;  // One band sample, two per word
  localparam int DATA_WIDTH_MUL = 32;  // Squared difference
  localparam int DATA_WIDTH_ACC = 48;  // Channel accumulator
  localparam int REF_WIDTH      = 12;  // Library index

  // One input element, pixel word a against library word b
  typedef struct packed {
    logic                  valid;    // Element present this cycle
    logic                  start;    // First element of a library vector
    logic                  last;     // Last element of a library vector
    logic [REF_WIDTH-1:0]  ref_idx;  // Library index of the vector
    logic [WORD_WIDTH-1:0] a;        // Pixel word
    logic [WORD_WIDTH-1:0] b;        // Library word
  } hsid_element_t;

  // Sum of squared differences of one channel
  typedef struct packed {
    logic                      valid;    // Sum complete
    logic                      last;     // Sum closes a vector
    logic [REF_WIDTH-1:0]      ref_idx;  // Library index of the sum
    logic [DATA_WIDTH_ACC-1:0] value;    // Running sum
  } hsid_acc_t;

  // Scaled score of one library vector
  typedef struct packed {
    logic                  valid;    // One-cycle strobe
    logic [REF_WIDTH-1:0]  ref_idx;  // Library index
    logic [WORD_WIDTH-1:0] value;    // MSE approximation
  } hsid_mse_t;

  // Best library entry of one pass
  typedef struct packed {
    logic                  valid;    // One-cycle strobe after the pass
    logic [REF_WIDTH-1:0]  ref_idx;  // Index of the lowest MSE
    logic [WORD_WIDTH-1:0] value;    // Lowest MSE
  } hsid_match_t;

endpackage

//--- source/hsid_sq_df_acc.sv
`timescale 1ns/1ns

module hsid_sq_df_acc import hsid_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  in_valid,  // Sample pair present
  input  logic                  in_start,  // First band of a vector
  input  logic                  in_last,   // Last band of a vector
  input  logic [REF_WIDTH-1:0]  in_ref,    // Library index
  input  logic [DATA_WIDTH-1:0] in_a,      // Pixel sample
  input  logic [DATA_WIDTH-1:0] in_b,      // Library sample
  output hsid_acc_t             acc        // Sum, valid on last band only
);

  // Difference stage
  logic                         s1_valid, s1_start, s1_last;
  logic [REF_WIDTH-1:0]         s1_ref;
  logic signed [DATA_WIDTH:0]   s1_diff;  // One bit wider, samples are unsigned

  // Square stage
  logic                         s2_valid, s2_start, s2_last;
  logic [REF_WIDTH-1:0]         s2_ref;
  logic [DATA_WIDTH_MUL-1:0]    s2_sq;

  // Accumulate stage
  logic                         acc_valid_q, acc_last_q;
  logic [REF_WIDTH-1:0]         acc_ref_q;
  logic [DATA_WIDTH_ACC-1:0]    acc_sum_q;

  logic signed [2*DATA_WIDTH+1:0] sq_full;  // Full signed product
  logic [DATA_WIDTH_ACC-1:0]      sq_ext;   // Square widened to the accumulator

  assign sq_full = s1_diff * s1_diff;  // Never exceeds 32 bits unsigned
  assign sq_ext  = {{(DATA_WIDTH_ACC-DATA_WIDTH_MUL){1'b0}}, s2_sq};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid    <= 1'b0;
      s1_start    <= 1'b0;
      s1_last     <= 1'b0;
      s2_valid    <= 1'b0;
      s2_start    <= 1'b0;
      s2_last     <= 1'b0;
      acc_valid_q <= 1'b0;
      acc_last_q  <= 1'b0;
    end else begin
      s1_valid    <= in_valid;
      s1_start    <= in_start;
      s1_last     <= in_last;
      s2_valid    <= s1_valid;
      s2_start    <= s1_start;
      s2_last     <= s1_last;
      acc_valid_q <= s2_valid && s2_last;  // Strobe only when the vector closes
      acc_last_q  <= s2_last;              // Stage flag as carried
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      s1_ref  <= in_ref;
      s1_diff <= $signed({1'b0, in_a}) - $signed({1'b0, in_b});  // Signed a - b
    end
    if (s1_valid) begin
      s2_ref <= s1_ref;
      s2_sq  <= sq_full[DATA_WIDTH_MUL-1:0];
    end
    if (s2_valid) begin
      acc_ref_q <= s2_ref;
      if (s2_start)
        acc_sum_q <= sq_ext;  // Start band loads, drops the previous vector
      else
        acc_sum_q <= acc_sum_q + sq_ext;
    end
  end

  assign acc.valid   = acc_valid_q;
  assign acc.last    = acc_last_q;
  assign acc.ref_idx = acc_ref_q;
  assign acc.value   = acc_sum_q;

  // Last flag only ever leaves together with a valid sum
  a_last_has_valid: assert property (
    @(posedge clk) disable iff (!rst_n) acc.last |-> acc.valid
  );

endmodule

//--- source/hsid_mse_reg.sv
`timescale 1ns/1ns

module hsid_mse_reg import hsid_pkg::*; #(
  parameter int HSI_BANDS = 254  // Bands per library vector
) (
  input  logic          clk,
  input  logic          rst_n,
  input  hsid_element_t element,  // One element per cycle
  output hsid_mse_t     mse       // Score per library vector
);

  localparam int BAND_SHIFT = $clog2(HSI_BANDS);  // Power-of-two mean

  // Input register
  logic                  el_valid_q, el_start_q, el_last_q;
  logic [REF_WIDTH-1:0]  el_ref_q;
  logic [WORD_WIDTH-1:0] el_a_q, el_b_q;

  // Channel results, lower and upper half of the word
  hsid_acc_t ch1_acc, ch2_acc;

  // Sum stage
  logic                  sum_valid_q;
  logic [REF_WIDTH-1:0]  sum_ref_q;
  logic [DATA_WIDTH_ACC:0] sum_value_q;  // One bit above the accumulator

  // Scale stage
  logic                  mse_valid_q;
  logic [REF_WIDTH-1:0]  mse_ref_q;
  logic [WORD_WIDTH-1:0] mse_value_q;

  logic                    sum_en;
  logic [DATA_WIDTH_ACC:0] sum_shifted;

  assign sum_en      = ch1_acc.valid && ch2_acc.valid;
  assign sum_shifted = sum_value_q >> BAND_SHIFT;  // Divide by band count, rounded up to 2^n

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      el_valid_q  <= 1'b0;
      el_start_q  <= 1'b0;
      el_last_q   <= 1'b0;
      sum_valid_q <= 1'b0;
      mse_valid_q <= 1'b0;
    end else begin
      el_valid_q  <= element.valid;
      el_start_q  <= element.valid && element.start;  // Flags count only with valid
      el_last_q   <= element.valid && element.last;
      sum_valid_q <= sum_en;
      mse_valid_q <= sum_valid_q;
    end
  end

  always_ff @(posedge clk) begin
    if (element.valid) begin
      el_ref_q <= element.ref_idx;
      el_a_q   <= element.a;
      el_b_q   <= element.b;
    end
    if (sum_en) begin
      sum_ref_q   <= ch1_acc.ref_idx;
      sum_value_q <= {1'b0, ch1_acc.value} + {1'b0, ch2_acc.value};
    end
    if (sum_valid_q) begin
      mse_ref_q   <= sum_ref_q;
      mse_value_q <= sum_shifted[WORD_WIDTH-1:0];  // Truncate to the word
    end
  end

  // Lower band of each word
  hsid_sq_df_acc channel_1 (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (el_valid_q),
    .in_start (el_start_q),
    .in_last  (el_last_q),
    .in_ref   (el_ref_q),
    .in_a     (el_a_q[DATA_WIDTH-1:0]),
    .in_b     (el_b_q[DATA_WIDTH-1:0]),
    .acc      (ch1_acc)
  );

  // Upper band of each word
  hsid_sq_df_acc channel_2 (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (el_valid_q),
    .in_start (el_start_q),
    .in_last  (el_last_q),
    .in_ref   (el_ref_q),
    .in_a     (el_a_q[WORD_WIDTH-1:DATA_WIDTH]),
    .in_b     (el_b_q[WORD_WIDTH-1:DATA_WIDTH]),
    .acc      (ch2_acc)
  );

  assign mse.valid   = mse_valid_q;
  assign mse.ref_idx = mse_ref_q;
  assign mse.value   = mse_value_q;

  // Both channels share one pipeline, so their sums must line up
  a_channels_aligned: assert property (
    @(posedge clk) disable iff (!rst_n)
      (ch1_acc.valid || ch2_acc.valid) |->
        (ch1_acc.valid && ch2_acc.valid && (ch1_acc.ref_idx == ch2_acc.ref_idx))
  );

endmodule

//--- source/hsid_min_tracker.sv
`timescale 1ns/1ns

module hsid_min_tracker import hsid_pkg::*; #(
  parameter int HSI_LIBRARY_SIZE = 4095  // Library vectors per pass
) (
  input  logic        clk,
  input  logic        rst_n,
  input  hsid_mse_t   mse,    // One score per library vector
  output hsid_match_t match   // Best entry, once per pass
);

  localparam logic [REF_WIDTH-1:0] LAST_REF = REF_WIDTH'(HSI_LIBRARY_SIZE - 1);

  logic                  pass_active_q;  // Between ref 0 and the last ref
  logic [REF_WIDTH-1:0]  last_ref_q;     // Ref of the previous score
  logic [REF_WIDTH-1:0]  best_ref_q;
  logic [WORD_WIDTH-1:0] best_value_q;

  logic                  match_valid_q;
  logic [REF_WIDTH-1:0]  match_ref_q;
  logic [WORD_WIDTH-1:0] match_value_q;

  logic first_ref, final_ref, take_new;

  assign first_ref = (mse.ref_idx == '0);
  assign final_ref = (mse.ref_idx == LAST_REF);
  // Strictly lower wins, so a tie keeps the lower index
  assign take_new  = first_ref || (pass_active_q && (mse.value < best_value_q));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pass_active_q <= 1'b0;
      match_valid_q <= 1'b0;
    end else begin
      match_valid_q <= mse.valid && final_ref;  // One-cycle strobe
      if (mse.valid) begin
        if (final_ref)
          pass_active_q <= 1'b0;  // Pass closed
        else if (first_ref)
          pass_active_q <= 1'b1;  // Fresh pass
      end
    end
  end

  always_ff @(posedge clk) begin
    if (mse.valid) begin
      last_ref_q <= mse.ref_idx;
      if (take_new) begin
        best_ref_q   <= mse.ref_idx;
        best_value_q <= mse.value;
      end
      if (final_ref) begin
        // Final entry takes part in the choice
        match_ref_q   <= take_new ? mse.ref_idx : best_ref_q;
        match_value_q <= take_new ? mse.value : best_value_q;
      end
    end
  end

  assign match.valid   = match_valid_q;
  assign match.ref_idx = match_ref_q;
  assign match.value   = match_value_q;

  // Scores of one pass arrive in library order without gaps
  a_ref_in_order: assert property (
    @(posedge clk) disable iff (!rst_n)
      (mse.valid && !first_ref) |->
        (pass_active_q && (mse.ref_idx == last_ref_q + 1'b1))
  );

endmodule

//--- source/hsid_top.sv
`timescale 1ns/1ns

module hsid_top import hsid_pkg::*; #(
  parameter int HSI_BANDS        = 254,   // Bands per library vector
  parameter int HSI_LIBRARY_SIZE = 4095   // Library vectors per pass
) (
  input  logic          clk,
  input  logic          rst_n,
  input  hsid_element_t element,  // Pixel and library words
  output hsid_mse_t     mse,      // Score per library vector
  output hsid_match_t   match     // Best entry of the pass
);

  hsid_mse_t mse_int;  // Score feeding the tracker and the output

  // Square differences, channel sums and scaling
  hsid_mse_reg #(
    .HSI_BANDS (HSI_BANDS)
  ) u_mse_reg (
    .clk     (clk),
    .rst_n   (rst_n),
    .element (element),
    .mse     (mse_int)
  );

  // Lowest score across the library
  hsid_min_tracker #(
    .HSI_LIBRARY_SIZE (HSI_LIBRARY_SIZE)
  ) u_min_tracker (
    .clk   (clk),
    .rst_n (rst_n),
    .mse   (mse_int),
    .match (match)
  );

  assign mse = mse_int;

endmodule

//--- verification/hsid_clk_gen.sv
`timescale 1ns/1ns

module hsid_clk_gen (
  input  logic rst_req,  // Extra reset request from the testbench
  output logic clk,
  output logic rst_n
);

  logic por_n;  // Power-on reset, low for 5 cycles

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // 10 ns period
  end

  initial begin
    por_n = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    por_n = 1'b1;  // Release away from the rising edge
  end

  assign rst_n = por_n && !rst_req;

endmodule

//--- verification/hsid_tb.sv
`timescale 1ns/1ns

module hsid_tb import hsid_pkg::*; ();

  localparam int BANDS      = 16;
  localparam int LIB_SIZE   = 6;
  localparam int BAND_SHIFT = $clog2(BANDS);  // Mean approximated by a shift
  localparam int MAX_WORDS  = 32;
  localparam int TIMEOUT    = 200;            // Cycles per wait

  logic          clk, rst_n, rst_req;
  hsid_element_t element;
  hsid_mse_t     mse;
  hsid_match_t   match;

  int          edge_count = 0;  // Rising edges since time zero
  int          error_count, tests_run, tests_failed;
  bit          timed_out;
  logic [31:0] lfsr_state;

  logic [WORD_WIDTH-1:0] vec_a [MAX_WORDS];  // Pixel words of the next vector
  logic [WORD_WIDTH-1:0] vec_b [MAX_WORDS];  // Library words of the next vector
  int                    vec_len;
  int                    last_sample_edge;   // Edge t of the last element
  logic [WORD_WIDTH-1:0] pass_value [LIB_SIZE];

  hsid_mse_t   exp_mse [$];
  hsid_mse_t   obs_mse [$];                  // Filled only by the monitor
  int          obs_mse_edge [$];
  hsid_match_t obs_match [$];
  int          obs_match_edge [$];
  int          mse_rd, match_rd;             // Read positions into the monitor queues

  hsid_clk_gen clk_gen0 (.rst_req(rst_req), .clk(clk), .rst_n(rst_n));

  hsid_top #(
    .HSI_BANDS        (BANDS),
    .HSI_LIBRARY_SIZE (LIB_SIZE)
  ) dut0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .element (element),
    .mse     (mse),
    .match   (match)
  );

  always @(posedge clk) edge_count <= edge_count + 1;

  always @(negedge clk) begin  // Outputs settled since the rising edge
    if (mse.valid === 1'b1) begin
      obs_mse.push_back(mse);
      obs_mse_edge.push_back(edge_count);
    end
    if (match.valid === 1'b1) begin
      obs_match.push_back(match);
      obs_match_edge.push_back(edge_count);
    end
  end

  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0])
      n = n ^ 32'h80200003;  // Taps 32, 22, 2, 1
    return n;
  endfunction

  function automatic logic [31:0] take_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r          = {r[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);  // One step per bit
    end
    return r;
  endfunction

  // Sum of squared band differences, scaled and cut to the word
  function automatic logic [WORD_WIDTH-1:0] model_mse();
    longint sum, d;
    sum = 0;
    for (int i = 0; i < vec_len; i++) begin
      d   = longint'(vec_a[i][15:0]) - longint'(vec_b[i][15:0]);
      sum = sum + d * d;
      d   = longint'(vec_a[i][31:16]) - longint'(vec_b[i][31:16]);
      sum = sum + d * d;
    end
    return WORD_WIDTH'(sum >> BAND_SHIFT);
  endfunction

  function automatic hsid_match_t model_best();
    hsid_match_t m;
    int          best;
    best = 0;
    for (int i = 1; i < LIB_SIZE; i++)
      if (pass_value[i] < pass_value[best])
        best = i;  // Strictly lower only, first index kept on a tie
    m.valid   = 1'b1;
    m.ref_idx = REF_WIDTH'(best);
    m.value   = pass_value[best];
    return m;
  endfunction

  task automatic drive_element(logic start, logic last, int ref_n,
                               logic [31:0] a, logic [31:0] b);
    @(negedge clk);
    element.valid    = 1'b1;
    element.start    = start;
    element.last     = last;
    element.ref_idx  = REF_WIDTH'(ref_n);
    element.a        = a;
    element.b        = b;
    last_sample_edge = edge_count;  // One edge before the input register takes it
  endtask

  task automatic drive_idle(int cycles);
    repeat (cycles) begin
      @(negedge clk);
      element = '0;
    end
  endtask

  task automatic load_random_vector(int len);
    vec_len = len;
    for (int i = 0; i < len; i++) begin
      vec_a[i] = take_bits(32);
      vec_b[i] = take_bits(32);
    end
  endtask

  task automatic load_equal_vector(int len);
    vec_len = len;
    for (int i = 0; i < len; i++) begin
      vec_a[i] = {16'(i * 7 + 3), 16'(i * 11 + 5)};  // Fixed, so repeatable
      vec_b[i] = vec_a[i];
    end
  endtask

  task automatic load_max_vector(int len);
    vec_len = len;
    for (int i = 0; i < len; i++) begin
      vec_a[i] = 32'hffff_ffff;
      vec_b[i] = 32'h0000_0000;
    end
  endtask

  task automatic send_vector(int ref_n, bit gaps);
    hsid_mse_t e;
    for (int i = 0; i < vec_len; i++) begin
      if (gaps)
        drive_idle(int'(take_bits(2)));  // 0 to 3 idle cycles
      drive_element(i == 0, i == vec_len - 1, ref_n, vec_a[i], vec_b[i]);
    end
    e.valid   = 1'b1;
    e.ref_idx = REF_WIDTH'(ref_n);
    e.value   = model_mse();
    exp_mse.push_back(e);
    if (ref_n < LIB_SIZE)
      pass_value[ref_n] = e.value;
  endtask

  task automatic run_pass(bit gaps);
    for (int r = 0; r < LIB_SIZE; r++) begin
      load_random_vector(8);
      send_vector(r, gaps);
    end
  endtask

  task automatic clear_results();
    mse_rd   = obs_mse.size();
    match_rd = obs_match.size();
    exp_mse.delete();
  endtask

  task automatic wait_for_results(int mse_count, int match_count);
    int cycles;
    cycles = 0;
    drive_idle(1);  // Drop valid after the last element
    while ((obs_mse.size() - mse_rd < mse_count || obs_match.size() - match_rd < match_count)
           && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (obs_mse.size() - mse_rd < mse_count || obs_match.size() - match_rd < match_count) begin
      $display("Timeout: waited %0d cycles for %0d mse and %0d match results",
               TIMEOUT, mse_count, match_count);
      timed_out = 1'b1;
      error_count++;
    end
  endtask

  task automatic wait_for_reset_release();
    int cycles;
    cycles = 0;
    while (rst_n !== 1'b1 && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (rst_n !== 1'b1) begin
      $display("Timeout: reset never released");
      timed_out = 1'b1;
      error_count++;
    end
  endtask

  task automatic compare_mse(hsid_mse_t got, hsid_mse_t exp);
    if (got.ref_idx !== exp.ref_idx) begin
      $display("ERR mse.ref_idx got %h exp %h", got.ref_idx, exp.ref_idx);
      error_count++;
    end
    if (got.value !== exp.value) begin
      $display("ERR mse.value got %h exp %h (ref %h)", got.value, exp.value, exp.ref_idx);
      error_count++;
    end
  endtask

  task automatic compare_match(hsid_match_t got, hsid_match_t exp);
    if (got.ref_idx !== exp.ref_idx) begin
      $display("ERR match.ref_idx got %h exp %h", got.ref_idx, exp.ref_idx);
      error_count++;
    end
    if (got.value !== exp.value) begin
      $display("ERR match.value got %h exp %h", got.value, exp.value);
      error_count++;
    end
  endtask

  task automatic check_mse_results();
    hsid_mse_t exp;
    while (exp_mse.size() > 0 && mse_rd < obs_mse.size()) begin
      exp = exp_mse.pop_front();
      compare_mse(obs_mse[mse_rd], exp);  // In library order
      mse_rd++;
    end
  endtask

  task automatic check_pass_match();
    int mse_edge;
    if (match_rd >= obs_match.size() || obs_mse.size() == 0)
      return;
    mse_edge = obs_mse_edge[obs_mse.size() - 1];  // Score of the final entry
    if (obs_match_edge[match_rd] != mse_edge + 1) begin
      $display("ERR match latency got %0h exp %0h", obs_match_edge[match_rd] - mse_edge, 1);
      error_count++;
    end
    compare_match(obs_match[match_rd], model_best());
    match_rd++;
  endtask

  task automatic expect_quiet();
    drive_idle(8);
    if (obs_mse.size() != mse_rd)
      $display("Unexpected mse result after the expected ones");
    if (obs_match.size() != match_rd)
      $display("Unexpected match result after the expected ones");
    if (obs_mse.size() != mse_rd || obs_match.size() != match_rd)
      error_count++;
  endtask

  task automatic finish_test(string name, int errs_before);
    tests_run++;
    if (error_count != errs_before) begin
      tests_failed++;
      $display("%s: FAIL", name);
    end else begin
      $display("%s: ok", name);
    end
  endtask

  task automatic single_vector_latency();
    int errs;
    errs = error_count;
    clear_results();
    vec_len = 8;
    for (int i = 0; i < 8; i++) begin
      vec_a[i] = {16'(1000 + 3 * i), 16'(200 + i)};
      vec_b[i] = {16'(990), 16'(210 + 2 * i)};
    end
    send_vector(0, 1'b0);
    wait_for_results(1, 0);
    if (mse_rd < obs_mse.size() && obs_mse_edge[mse_rd] - last_sample_edge != 6) begin
      $display("ERR mse latency got %0h exp %0h", obs_mse_edge[mse_rd] - last_sample_edge, 6);
      error_count++;
    end
    check_mse_results();
    expect_quiet();
    finish_test("single vector latency", errs);
  endtask

  task automatic half_word_independence();
    int          errs;
    logic [15:0] x, y, same;
    errs = error_count;
    clear_results();
    vec_len = 8;
    for (int i = 0; i < 8; i++) begin  // Upper band differs only
      x        = 16'(take_bits(16));
      y        = 16'(take_bits(16));
      same     = 16'(take_bits(16));
      vec_a[i] = {x, same};
      vec_b[i] = {y, same};
    end
    send_vector(1, 1'b0);
    drive_idle(3);
    for (int i = 0; i < 8; i++) begin  // Lower band differs only
      x        = 16'(take_bits(16));
      y        = 16'(take_bits(16));
      same     = 16'(take_bits(16));
      vec_a[i] = {same, x};
      vec_b[i] = {same, y};
    end
    send_vector(2, 1'b0);
    wait_for_results(2, 0);
    check_mse_results();
    expect_quiet();
    finish_test("half word independence", errs);
  endtask

  task automatic back_to_back_start();
    int errs;
    errs = error_count;
    clear_results();
    load_random_vector(8);
    send_vector(3, 1'b0);
    load_random_vector(8);
    send_vector(4, 1'b0);  // Start element follows last without a gap
    wait_for_results(2, 0);
    check_mse_results();
    expect_quiet();
    finish_test("back to back start", errs);
  endtask

  task automatic library_pass_random();
    int errs;
    errs = error_count;
    clear_results();
    run_pass(1'b1);
    wait_for_results(LIB_SIZE, 1);
    check_pass_match();
    check_mse_results();
    expect_quiet();
    finish_test("library pass random", errs);
  endtask

  task automatic ties_and_extremes();
    int errs;
    errs = error_count;
    clear_results();
    load_random_vector(8);
    send_vector(0, 1'b0);
    load_max_vector(32);   // Scaled sum exceeds the word
    send_vector(1, 1'b0);
    load_equal_vector(8);  // Zero difference, the minimum
    send_vector(2, 1'b1);
    load_random_vector(8);
    send_vector(3, 1'b0);
    load_equal_vector(8);  // Same minimum again at a higher index
    send_vector(4, 1'b0);
    load_random_vector(8);
    send_vector(5, 1'b1);
    wait_for_results(LIB_SIZE, 1);
    check_pass_match();
    check_mse_results();
    expect_quiet();
    finish_test("ties and extremes", errs);
  endtask

  task automatic reset_mid_vector();
    int errs;
    errs = error_count;
    clear_results();
    load_random_vector(8);
    send_vector(LIB_SIZE - 1, 1'b0);  // Final entry, score and match still in flight
    for (int i = 0; i < 4; i++)
      drive_element(i == 0, 1'b0, 0, vec_a[i], vec_b[i]);  // Half a vector
    @(negedge clk);
    element = '0;
    rst_req = 1'b1;
    repeat (3) begin  // Spans the edges where mse and match were due
      @(negedge clk);
      if (mse.valid !== 1'b0) begin
        $display("ERR mse.valid got %h exp %h", mse.valid, 1'b0);
        error_count++;
      end
      if (match.valid !== 1'b0) begin
        $display("ERR match.valid got %h exp %h", match.valid, 1'b0);
        error_count++;
      end
    end
    rst_req = 1'b0;
    wait_for_reset_release();
    expect_quiet();  // Flushed vectors give no score
    clear_results();
    run_pass(1'b0);
    wait_for_results(LIB_SIZE, 1);
    check_pass_match();
    check_mse_results();
    expect_quiet();
    finish_test("reset mid vector", errs);
  endtask

  initial begin
    element      = '0;
    rst_req      = 1'b0;
    lfsr_state   = 32'hd623;
    error_count  = 0;
    tests_run    = 0;
    tests_failed = 0;
    timed_out    = 1'b0;
    mse_rd       = 0;
    match_rd     = 0;
    vec_len      = 0;
    wait_for_reset_release();
    if (!timed_out) single_vector_latency();
    if (!timed_out) half_word_independence();
    if (!timed_out) back_to_back_start();
    if (!timed_out) library_pass_random();
    if (!timed_out) ties_and_extremes();
    if (!timed_out) reset_mid_vector();
    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
    if (error_count == 0 && !timed_out) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- list.f
source/hsid_pkg.sv
source/hsid_sq_df_acc.sv
source/hsid_mse_reg.sv
source/hsid_min_tracker.sv
source/hsid_top.sv
verification/hsid_clk_gen.sv
verification/hsid_tb.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build hsid_tb with Verilator, run it and check sim.log"
	@echo "  clean  remove the Verilator build folder and the log"

test:
	rm -rf obj_dir sim.log
	verilator --binary --timing --assert --top-module hsid_tb -f list.f -o hsid_sim
	./obj_dir/hsid_sim | tee sim.log
	grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log
